// File: verilog/decoder_pkg.sv
package decoder_pkg;

    function automatic int max_int(int a, int b);
        return (a > b) ? a : b;
    endfunction

    //////////////////////////////
    // lattice shape and widths.
    localparam int CODE_DISTANCE_X = 3;  // rows.
    localparam int CODE_DISTANCE_Z = 2;  // columns.
    localparam int MEASUREMENT_ROUNDS = max_int(CODE_DISTANCE_X, CODE_DISTANCE_Z);
    localparam int NODE_COUNT = CODE_DISTANCE_X * CODE_DISTANCE_Z * MEASUREMENT_ROUNDS;
    localparam int PER_DIM_BIT_WIDTH = $clog2(MEASUREMENT_ROUNDS);
    localparam int ADDRESS_WIDTH = PER_DIM_BIT_WIDTH * 3;

    localparam int WEIGHT_X = 2;  // north-south.
    localparam int WEIGHT_Z = 2;  // east-west.
    localparam int WEIGHT_M = 2;  // up-down, between rounds.
    localparam int EDGE_COUNT_WIDTH =
        $clog2(max_int(max_int(WEIGHT_X, WEIGHT_Z), WEIGHT_M) + 1);

    localparam int NS_EDGE_COUNT = (CODE_DISTANCE_X - 1) * CODE_DISTANCE_Z * MEASUREMENT_ROUNDS;
    localparam int EW_EDGE_COUNT = CODE_DISTANCE_X * (CODE_DISTANCE_Z - 1) * MEASUREMENT_ROUNDS;
    localparam int UD_EDGE_COUNT = CODE_DISTANCE_X * CODE_DISTANCE_Z * (MEASUREMENT_ROUNDS - 1);
    localparam int GROW_WIDTH = 4;

    //////////////////////////////
    typedef logic [NODE_COUNT-1:0] node_vec_t;
    typedef logic [ADDRESS_WIDTH-1:0] node_addr_t;
    typedef node_addr_t [NODE_COUNT-1:0] root_array_t;
    typedef logic [GROW_WIDTH-1:0] grow_count_t;
    typedef logic [EDGE_COUNT_WIDTH-1:0] edge_count_t;

    typedef enum logic [1:0] {
        stage_idle,
        stage_load,
        stage_grow,
        stage_merge
    } decode_stage_t;

    typedef struct packed {
        logic [NS_EDGE_COUNT-1:0] ns;
        logic [EW_EDGE_COUNT-1:0] ew;
    } planar_grown_t;

    typedef struct packed {
        decode_stage_t stage;
        node_vec_t defects;
    } stage_bus_t;

    //////////////////////////////
    // round-major numbering of nodes and edges.
    function automatic int node_index(int row, int col, int round);
        return row * CODE_DISTANCE_Z + col + round * CODE_DISTANCE_X * CODE_DISTANCE_Z;
    endfunction

    // edge below node (row, col).
    function automatic int ns_edge_index(int row, int col, int round);
        return row * CODE_DISTANCE_Z + col + round * (CODE_DISTANCE_X - 1) * CODE_DISTANCE_Z;
    endfunction

    // edge right of node (row, col).
    function automatic int ew_edge_index(int row, int col, int round);
        return row * (CODE_DISTANCE_Z - 1) + col + round * CODE_DISTANCE_X * (CODE_DISTANCE_Z - 1);
    endfunction

    function automatic int ud_edge_index(int row, int col, int round);
        return node_index(row, col, round);  // joins round and round + 1.
    endfunction

    // add defect endpoints, saturate at the weight.
    function automatic edge_count_t grow_step(edge_count_t count, logic a, logic b, int weight);
        logic [EDGE_COUNT_WIDTH:0] sum;
        sum = count + a + b;
        return (sum >= weight) ? edge_count_t'(weight) : edge_count_t'(sum);
    endfunction

    function automatic root_array_t self_roots();
        root_array_t roots;
        for (int i = 0; i < NODE_COUNT; i++) begin
            roots[i] = node_addr_t'(i);
        end
        return roots;
    endfunction

    localparam root_array_t SELF_ROOTS = self_roots();

endpackage

// File: verilog/decode_sequencer.sv
module decode_sequencer (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       start,
    input  decoder_pkg::node_vec_t     measurements,
    input  decoder_pkg::grow_count_t   grow_cycles,
    input  logic                       changed,
    output decoder_pkg::stage_bus_t    stage_bus,
    output logic                       busy,
    output logic                       done
);

    decoder_pkg::decode_stage_t stage;
    decoder_pkg::node_vec_t defects;
    decoder_pkg::grow_count_t grow_left;

    //////////////////////////////
    // stage FSM.
    always_ff @(posedge clk) begin
        if (rst) begin
            stage <= decoder_pkg::stage_idle;
            grow_left <= '0;
            done <= 1'b0;
        end else begin
            done <= 1'b0;
            case (stage)
                decoder_pkg::stage_idle: begin
                    if (start) begin
                        stage <= decoder_pkg::stage_load;
                        grow_left <= grow_cycles;
                    end
                end
                decoder_pkg::stage_load: begin
                    if (grow_left == '0) begin
                        stage <= decoder_pkg::stage_merge;  // nothing to grow.
                    end else begin
                        stage <= decoder_pkg::stage_grow;
                    end
                end
                decoder_pkg::stage_grow: begin
                    grow_left <= grow_left - 1'b1;
                    if (grow_left == decoder_pkg::grow_count_t'(1)) begin
                        stage <= decoder_pkg::stage_merge;
                    end
                end
                decoder_pkg::stage_merge: begin
                    // settled roots end the decode.
                    if (!changed) begin
                        stage <= decoder_pkg::stage_idle;
                        done <= 1'b1;
                    end
                end
                default: begin
                    stage <= decoder_pkg::stage_idle;
                end
            endcase
        end
    end

    // syndrome latch.
    always_ff @(posedge clk) begin
        if (stage == decoder_pkg::stage_idle && start) begin
            defects <= measurements;
        end
    end

    assign stage_bus = '{stage: stage, defects: defects};
    assign busy = (stage != decoder_pkg::stage_idle);

endmodule

// File: verilog/planar_links.sv
module planar_links (
    input  logic                        clk,
    input  logic                        rst,
    input  decoder_pkg::stage_bus_t     stage_bus,
    output decoder_pkg::planar_grown_t  planar_grown
);

    decoder_pkg::edge_count_t [decoder_pkg::NS_EDGE_COUNT-1:0] ns_count;
    decoder_pkg::edge_count_t [decoder_pkg::EW_EDGE_COUNT-1:0] ew_count;

    //////////////////////////////
    // growth counters, one per edge inside a round.
    always_ff @(posedge clk) begin
        if (rst) begin
            ns_count <= '0;
            ew_count <= '0;
        end else if (stage_bus.stage == decoder_pkg::stage_load) begin
            ns_count <= '0;
            ew_count <= '0;
        end else if (stage_bus.stage == decoder_pkg::stage_grow) begin
            for (int k = 0; k < decoder_pkg::MEASUREMENT_ROUNDS; k++) begin
                // north-south pairs.
                for (int r = 0; r < decoder_pkg::CODE_DISTANCE_X - 1; r++) begin
                    for (int c = 0; c < decoder_pkg::CODE_DISTANCE_Z; c++) begin
                        ns_count[decoder_pkg::ns_edge_index(r, c, k)] <= decoder_pkg::grow_step(
                            ns_count[decoder_pkg::ns_edge_index(r, c, k)],
                            stage_bus.defects[decoder_pkg::node_index(r, c, k)],
                            stage_bus.defects[decoder_pkg::node_index(r + 1, c, k)],
                            decoder_pkg::WEIGHT_X
                        );
                    end
                end
                // east-west pairs.
                for (int r = 0; r < decoder_pkg::CODE_DISTANCE_X; r++) begin
                    for (int c = 0; c < decoder_pkg::CODE_DISTANCE_Z - 1; c++) begin
                        ew_count[decoder_pkg::ew_edge_index(r, c, k)] <= decoder_pkg::grow_step(
                            ew_count[decoder_pkg::ew_edge_index(r, c, k)],
                            stage_bus.defects[decoder_pkg::node_index(r, c, k)],
                            stage_bus.defects[decoder_pkg::node_index(r, c + 1, k)],
                            decoder_pkg::WEIGHT_Z
                        );
                    end
                end
            end
        end
    end

    // an edge is grown once its counter reaches the weight.
    always_comb begin
        for (int i = 0; i < decoder_pkg::NS_EDGE_COUNT; i++) begin
            planar_grown.ns[i] =
                (ns_count[i] == decoder_pkg::edge_count_t'(decoder_pkg::WEIGHT_X));
        end
        for (int i = 0; i < decoder_pkg::EW_EDGE_COUNT; i++) begin
            planar_grown.ew[i] =
                (ew_count[i] == decoder_pkg::edge_count_t'(decoder_pkg::WEIGHT_Z));
        end
    end

endmodule

// File: verilog/time_links.sv
module time_links (
    input  logic                                   clk,
    input  logic                                   rst,
    input  decoder_pkg::stage_bus_t                stage_bus,
    output logic [decoder_pkg::UD_EDGE_COUNT-1:0]  ud_grown
);

    decoder_pkg::edge_count_t [decoder_pkg::UD_EDGE_COUNT-1:0] ud_count;

    //////////////////////////////
    // one counter per node pair in adjacent rounds.
    always_ff @(posedge clk) begin
        if (rst) begin
            ud_count <= '0;
        end else if (stage_bus.stage == decoder_pkg::stage_load) begin
            ud_count <= '0;
        end else if (stage_bus.stage == decoder_pkg::stage_grow) begin
            for (int k = 0; k < decoder_pkg::MEASUREMENT_ROUNDS - 1; k++) begin
                for (int r = 0; r < decoder_pkg::CODE_DISTANCE_X; r++) begin
                    for (int c = 0; c < decoder_pkg::CODE_DISTANCE_Z; c++) begin
                        ud_count[decoder_pkg::ud_edge_index(r, c, k)] <= decoder_pkg::grow_step(
                            ud_count[decoder_pkg::ud_edge_index(r, c, k)],
                            stage_bus.defects[decoder_pkg::node_index(r, c, k)],
                            stage_bus.defects[decoder_pkg::node_index(r, c, k + 1)],
                            decoder_pkg::WEIGHT_M  // weight of the up-down edges.
                        );
                    end
                end
            end
        end
    end

    always_comb begin
        for (int i = 0; i < decoder_pkg::UD_EDGE_COUNT; i++) begin
            ud_grown[i] = (ud_count[i] == decoder_pkg::edge_count_t'(decoder_pkg::WEIGHT_M));
        end
    end

endmodule

// File: verilog/cluster_merge.sv
module cluster_merge (
    input  logic                                   clk,
    input  logic                                   rst,
    input  decoder_pkg::stage_bus_t                stage_bus,
    input  decoder_pkg::planar_grown_t             planar_grown,
    input  logic [decoder_pkg::UD_EDGE_COUNT-1:0]  ud_grown,
    output decoder_pkg::root_array_t               roots,
    output logic                                   changed
);

    decoder_pkg::root_array_t next_roots;

    // take the neighbor root only across a grown edge.
    function automatic decoder_pkg::node_addr_t pick(
        decoder_pkg::node_addr_t best,
        logic grown,
        decoder_pkg::node_addr_t cand
    );
        return (grown && cand < best) ? cand : best;
    endfunction

    //////////////////////////////
    // one hop of minimum-root propagation.
    always_comb begin
        decoder_pkg::node_addr_t best;
        int node;
        next_roots = roots;
        for (int k = 0; k < decoder_pkg::MEASUREMENT_ROUNDS; k++) begin
            for (int r = 0; r < decoder_pkg::CODE_DISTANCE_X; r++) begin
                for (int c = 0; c < decoder_pkg::CODE_DISTANCE_Z; c++) begin
                    node = decoder_pkg::node_index(r, c, k);
                    best = roots[node];
                    if (r > 0) begin  // north.
                        best = pick(best, planar_grown.ns[decoder_pkg::ns_edge_index(r - 1, c, k)],
                            roots[decoder_pkg::node_index(r - 1, c, k)]);
                    end
                    if (r < decoder_pkg::CODE_DISTANCE_X - 1) begin  // south.
                        best = pick(best, planar_grown.ns[decoder_pkg::ns_edge_index(r, c, k)],
                            roots[decoder_pkg::node_index(r + 1, c, k)]);
                    end
                    if (c > 0) begin  // west.
                        best = pick(best, planar_grown.ew[decoder_pkg::ew_edge_index(r, c - 1, k)],
                            roots[decoder_pkg::node_index(r, c - 1, k)]);
                    end
                    if (c < decoder_pkg::CODE_DISTANCE_Z - 1) begin  // east.
                        best = pick(best, planar_grown.ew[decoder_pkg::ew_edge_index(r, c, k)],
                            roots[decoder_pkg::node_index(r, c + 1, k)]);
                    end
                    if (k > 0) begin  // down.
                        best = pick(best, ud_grown[decoder_pkg::ud_edge_index(r, c, k - 1)],
                            roots[decoder_pkg::node_index(r, c, k - 1)]);
                    end
                    if (k < decoder_pkg::MEASUREMENT_ROUNDS - 1) begin  // up.
                        best = pick(best, ud_grown[decoder_pkg::ud_edge_index(r, c, k)],
                            roots[decoder_pkg::node_index(r, c, k + 1)]);
                    end
                    next_roots[node] = best;
                end
            end
        end
    end

    //////////////////////////////
    // root registers.
    always_ff @(posedge clk) begin
        if (rst) begin
            roots <= decoder_pkg::SELF_ROOTS;
        end else if (stage_bus.stage == decoder_pkg::stage_load) begin
            roots <= decoder_pkg::SELF_ROOTS;  // every node its own cluster.
        end else if (stage_bus.stage == decoder_pkg::stage_merge) begin
            roots <= next_roots;
        end
    end

    // low once the clusters have settled.
    assign changed = (stage_bus.stage == decoder_pkg::stage_merge) && (next_roots != roots);

endmodule

// File: verilog/decoding_graph.sv
module decoding_graph (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       start,
    input  decoder_pkg::node_vec_t     measurements,
    input  decoder_pkg::grow_count_t   grow_cycles,
    output decoder_pkg::root_array_t   roots,
    output logic                       busy,
    output logic                       done
);

    decoder_pkg::stage_bus_t stage_bus;
    decoder_pkg::planar_grown_t planar_grown;
    logic [decoder_pkg::UD_EDGE_COUNT-1:0] ud_grown;
    logic changed;

    //////////////////////////////
    decode_sequencer sequencer0 (
        .clk(clk),
        .rst(rst),
        .start(start),
        .measurements(measurements),
        .grow_cycles(grow_cycles),
        .changed(changed),
        .stage_bus(stage_bus),
        .busy(busy),
        .done(done)
    );

    // edges inside each round.
    planar_links planar0 (
        .clk(clk),
        .rst(rst),
        .stage_bus(stage_bus),
        .planar_grown(planar_grown)
    );

    // edges between rounds.
    time_links time0 (
        .clk(clk),
        .rst(rst),
        .stage_bus(stage_bus),
        .ud_grown(ud_grown)
    );

    //////////////////////////////
    cluster_merge merge0 (
        .clk(clk),
        .rst(rst),
        .stage_bus(stage_bus),
        .planar_grown(planar_grown),
        .ud_grown(ud_grown),
        .roots(roots),
        .changed(changed)
    );

endmodule

// File: test/decoding_graph_tb.sv
module decoding_graph_tb;

    logic clk;
    logic rst;
    logic start;
    decoder_pkg::node_vec_t measurements;
    decoder_pkg::grow_count_t grow_cycles;
    decoder_pkg::root_array_t roots;
    logic busy;
    logic done;

    // one entry per trace line.
    string test_names[$];
    decoder_pkg::node_vec_t test_meas[$];
    decoder_pkg::grow_count_t test_grow[$];
    decoder_pkg::root_array_t test_roots[$];

    int cycle_count = 0;
    int cycle_limit = 0;

    decoding_graph dut0 (
        .clk(clk),
        .rst(rst),
        .start(start),
        .measurements(measurements),
        .grow_cycles(grow_cycles),
        .roots(roots),
        .busy(busy),
        .done(done)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_limit > 0 && cycle_count >= cycle_limit) begin
            $display("timeout: the run went past %0d cycles without finishing", cycle_limit);
            $display("Testbench failed");
            $fatal(1);
        end
    end

    //////////////////////////////
    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("Testbench failed");
        $fatal(1);
    endtask

    task automatic check_value(input string test_name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (expected !== actual) begin
            $display("** Error: %s expected %0h actual %0h", test_name, expected, actual);
            $display("Testbench failed");
            $fatal(1);
        end
    endtask

    task automatic check_roots(input string test_name,
                               input decoder_pkg::root_array_t expected);
        for (int i = 0; i < decoder_pkg::NODE_COUNT; i++) begin
            check_value($sformatf("%s root %0d", test_name, i), expected[i], roots[i]);
        end
    endtask

    //////////////////////////////
    // name, measurements, grow cycles, then 18 roots.
    task automatic read_trace();
        int fd;
        int code;
        string token;
        string rest;
        logic [31:0] meas_value;
        int grow_value;
        logic [31:0] root_value;
        decoder_pkg::root_array_t expected;
        fd = $fopen("test/decode_trace.txt", "r");
        if (fd == 0) begin
            abort_run("could not open the trace file test/decode_trace.txt");
        end else begin
            while ($fscanf(fd, "%s", token) == 1) begin
                if (token.substr(0, 0) == "#") begin
                    code = $fgets(rest, fd);  // column notes.
                end else begin
                    code = $fscanf(fd, "%h %d", meas_value, grow_value);
                    if (code != 2) begin
                        abort_run({"bad measurement or grow field in trace line ", token});
                    end else begin
                        for (int i = 0; i < decoder_pkg::NODE_COUNT; i++) begin
                            code = $fscanf(fd, "%h", root_value);
                            if (code != 1) begin
                                abort_run({"missing expected root in trace line ", token});
                            end else begin
                                expected[i] = decoder_pkg::node_addr_t'(root_value);
                            end
                        end
                        test_names.push_back(token);
                        test_meas.push_back(decoder_pkg::node_vec_t'(meas_value));
                        test_grow.push_back(decoder_pkg::grow_count_t'(grow_value));
                        test_roots.push_back(expected);
                    end
                end
            end
            $fclose(fd);
        end
    endtask

    //////////////////////////////
    task automatic run_test(input int t);
        string name;
        decoder_pkg::root_array_t expected;
        name = test_names[t];
        expected = test_roots[t];
        @(negedge clk);
        start = 1'b1;
        measurements = test_meas[t];
        grow_cycles = test_grow[t];
        @(negedge clk);
        start = 1'b0;
        check_value({name, " busy in load"}, 1, busy);
        @(negedge clk);
        // second start with other inputs, must not restart.
        check_value({name, " busy before second start"}, 1, busy);
        start = 1'b1;
        measurements = ~test_meas[t];
        grow_cycles = ~test_grow[t];
        @(negedge clk);
        start = 1'b0;
        while (!done) begin
            @(negedge clk);
        end
        check_roots(name, expected);
        @(negedge clk);
        check_value({name, " done after one cycle"}, 0, done);
        check_value({name, " busy after done"}, 0, busy);
        check_roots({name, " held"}, expected);
    endtask

    initial begin
        decoder_pkg::root_array_t own_roots;
        rst = 1'b1;
        start = 1'b0;
        measurements = '0;
        grow_cycles = '0;
        for (int i = 0; i < decoder_pkg::NODE_COUNT; i++) begin
            own_roots[i] = decoder_pkg::node_addr_t'(i);  // each node its own root.
        end
        read_trace();
        if (test_names.size() == 0) begin
            abort_run("the trace file holds no tests");
        end else begin
            cycle_limit = test_names.size() * (16 + decoder_pkg::NODE_COUNT + 10);
            repeat (8) @(negedge clk);
            rst = 1'b0;
            @(negedge clk);
            check_value("reset busy", 0, busy);
            check_value("reset done", 0, done);
            check_roots("reset", own_roots);
            for (int t = 0; t < test_names.size(); t++) begin
                run_test(t);
            end
            $display("Testbench passed");
            $finish;
        end
    end

endmodule

// File: test/decode_trace.txt
# name  measurements (hex, bit n is node n)  grow_cycles (decimal)
# then the expected roots of nodes 0 to 17 (hex)
no_defects 00000 3 00 01 02 03 04 05 06 07 08 09 0a 0b 0c 0d 0e 0f 10 11
ns_pair_lone 08014 1 00 01 02 03 02 05 06 07 08 09 0a 0b 0c 0d 0e 0f 10 11
single_up_down 00200 2 00 01 02 03 04 05 06 03 03 03 0a 03 0c 0d 0e 03 10 11
chain_rounds 04104 2 00 01 00 00 00 05 00 07 00 00 00 0b 00 0d 00 00 00 11
dense_all 3ffff 15 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00
no_defects_again 00000 3 00 01 02 03 04 05 06 07 08 09 0a 0b 0c 0d 0e 0f 10 11
ew_pair 00003 1 00 00 02 03 04 05 06 07 08 09 0a 0b 0c 0d 0e 0f 10 11
ud_pair 00820 1 00 01 02 03 04 05 06 07 08 09 0a 05 0c 0d 0e 0f 10 11
zero_grow 00003 0 00 01 02 03 04 05 06 07 08 09 0a 0b 0c 0d 0e 0f 10 11
lone_one_cycle 00080 1 00 01 02 03 04 05 06 07 08 09 0a 0b 0c 0d 0e 0f 10 11
corner_single 20000 2 00 01 02 03 04 05 06 07 08 09 0a 0b 0c 0d 0e 0b 0b 0b
diagonal_pair 00009 1 00 01 02 03 04 05 06 07 08 09 0a 0b 0c 0d 0e 0f 10 11
column_chain 0002a 1 00 01 02 01 04 01 06 07 08 09 0a 0b 0c 0d 0e 0f 10 11
time_pillar 10410 1 00 01 02 03 04 05 06 07 08 09 04 0b 0c 0d 0e 0f 04 11
two_pairs 0a005 1 00 01 00 03 04 05 06 07 08 09 0a 0b 0c 0d 0e 0d 10 11
two_clusters 0a005 2 00 00 00 00 00 05 00 07 00 07 0a 0b 07 07 07 07 10 07
dense_one_cycle 3ffff 1 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00
round1_plane 00fc0 1 00 01 02 03 04 05 06 06 06 06 06 06 0c 0d 0e 0f 10 11
round1_bridge 00fc0 2 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00 00
l_shape 0000b 1 00 00 02 00 04 05 06 07 08 09 0a 0b 0c 0d 0e 0f 10 11
single_max_grow 00001 15 00 00 00 03 04 05 00 07 08 09 0a 0b 0c 0d 0e 0f 10 11
split_rounds 01020 2 00 01 02 03 03 03 06 07 08 09 0a 03 06 06 06 0f 10 11

// File: verilog.f
verilog/decoder_pkg.sv
verilog/decode_sequencer.sv
verilog/planar_links.sv
verilog/time_links.sv
verilog/cluster_merge.sv
verilog/decoding_graph.sv
test/decoding_graph_tb.sv
